// ==== design/render_cfg.svh ====
`ifndef RENDER_CFG_SVH
`define RENDER_CFG_SVH

// screen size in pixels.
`define RENDER_WIDTH  32
`define RENDER_HEIGHT 24

// 1 drops triangles with negative signed area.
`define RENDER_CULL   1

`endif

// ==== design/render_pkg.sv ====
package render_pkg;

    // signed fixed point, 16 integer and 16 fraction bits.
    typedef logic signed [31:0] q16_16_t;

    typedef logic [15:0] coord_t; // screen pixel coordinate.
    typedef logic [11:0] color12_t; // 4 bits per channel, r in the top nibble.

    // depth written by the screen fill.
    localparam q16_16_t FAR_DEPTH = 32'sh7fff_ffff;

endpackage

// ==== design/tri_if.sv ====
`timescale 1ns/1ps

interface tri_if;
    import render_pkg::*;

    q16_16_t  v0_x;
    q16_16_t  v0_y;
    q16_16_t  v0_z;
    q16_16_t  v1_x;
    q16_16_t  v1_y;
    q16_16_t  v1_z;
    q16_16_t  v2_x;
    q16_16_t  v2_y;
    q16_16_t  v2_z;
    color12_t color;
    logic     valid;
    logic     ready;

    modport src (
        output v0_x, v0_y, v0_z, v1_x, v1_y, v1_z, v2_x, v2_y, v2_z,
        output color, valid,
        input  ready
    );

    modport dst (
        input  v0_x, v0_y, v0_z, v1_x, v1_y, v1_z, v2_x, v2_y, v2_z,
        input  color, valid,
        output ready
    );

endinterface

// ==== design/pixel_if.sv ====
`timescale 1ns/1ps

interface pixel_if;
    import render_pkg::*;

    coord_t   x;
    coord_t   y;
    q16_16_t  depth;
    color12_t color;
    logic     compare_depth; // low for fill pixels.
    logic     valid;
    logic     ready;

    modport src (
        output x, y, depth, color, compare_depth, valid,
        input  ready
    );

    modport dst (
        input  x, y, depth, color, compare_depth, valid,
        output ready
    );

endinterface

// ==== design/render_regs.sv ====
`timescale 1ns/1ps

module render_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 reg_wr,
    input  logic [1:0]           reg_addr,
    input  render_pkg::q16_16_t  reg_data,
    output render_pkg::color12_t fill_color,
    output render_pkg::q16_16_t  focal_length,
    output render_pkg::q16_16_t  cam_x,
    output render_pkg::q16_16_t  cam_y
);
    import render_pkg::*;

    localparam q16_16_t UNIT = 32'sh0001_0000; // 1.0

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_color   <= '0;
            focal_length <= UNIT;
            cam_x        <= '0;
            cam_y        <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                2'd0: fill_color <= reg_data[11:0]; // colour sits in the low bits.
                2'd1: focal_length <= reg_data;
                2'd2: cam_x <= reg_data;
                default: cam_y <= reg_data;
            endcase
        end
    end

endmodule

// ==== design/screen_filler.sv ====
`timescale 1ns/1ps
`include "render_cfg.svh"

module screen_filler (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  render_pkg::color12_t color,
    output logic                 busy,
    pixel_if.src                 pix
);
    import render_pkg::*;

    localparam coord_t X_LAST = coord_t'(`RENDER_WIDTH - 1);
    localparam coord_t Y_LAST = coord_t'(`RENDER_HEIGHT - 1);

    coord_t x;
    coord_t y;

    // row-major walk, one location per accepted pixel.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            x    <= '0;
            y    <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                x    <= '0;
                y    <= '0;
            end
        end else if (pix.ready) begin
            if (x == X_LAST) begin
                x <= '0;
                if (y == Y_LAST) begin
                    busy <= 1'b0; // last location sent.
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    assign pix.x             = x;
    assign pix.y             = y;
    assign pix.depth         = FAR_DEPTH;
    assign pix.color         = color;
    assign pix.compare_depth = 1'b0;
    assign pix.valid         = busy;

endmodule

// ==== design/transformer.sv ====
`timescale 1ns/1ps

module transformer (
    input  logic                clk,
    input  logic                rst,
    input  render_pkg::q16_16_t focal_length,
    input  render_pkg::q16_16_t cam_x,
    input  render_pkg::q16_16_t cam_y,
    input  render_pkg::q16_16_t tx,
    input  render_pkg::q16_16_t ty,
    input  render_pkg::q16_16_t tz,
    tri_if.dst                  in,
    tri_if.src                  out,
    output logic                busy
);
    import render_pkg::*;

    q16_16_t  in_x [3];
    q16_16_t  in_y [3];
    q16_16_t  in_z [3];
    color12_t in_color;
    logic     in_full;

    q16_16_t  wx [3];
    q16_16_t  wy [3];
    q16_16_t  wz [3];
    color12_t w_color;
    logic [1:0] phase; // 0 empty, 1 offset added, 2 camera removed, 3 scaled.

    logic take;
    logic load;
    logic drain;

    // q16.16 product, middle word kept.
    function automatic q16_16_t scale(input q16_16_t a, input q16_16_t f);
        logic signed [63:0] p;
        p = a * f;
        return p[47:16];
    endfunction

    assign take  = in.valid && in.ready;
    assign load  = in_full && (phase == 2'd0);
    assign drain = out.valid && out.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_full <= 1'b0;
            phase   <= 2'd0;
        end else begin
            if (take) begin
                in_full <= 1'b1;
            end else if (load) begin
                in_full <= 1'b0;
            end
            if (load) begin
                phase <= 2'd1;
            end else if (phase == 2'd1 || phase == 2'd2) begin
                phase <= phase + 2'd1;
            end else if (drain) begin
                phase <= 2'd0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            in_x[0]  <= in.v0_x;
            in_y[0]  <= in.v0_y;
            in_z[0]  <= in.v0_z;
            in_x[1]  <= in.v1_x;
            in_y[1]  <= in.v1_y;
            in_z[1]  <= in.v1_z;
            in_x[2]  <= in.v2_x;
            in_y[2]  <= in.v2_y;
            in_z[2]  <= in.v2_z;
            in_color <= in.color;
        end
        if (load) begin
            w_color <= in_color;
        end
        for (int i = 0; i < 3; i++) begin
            if (load) begin
                wx[i] <= in_x[i] + tx;
                wy[i] <= in_y[i] + ty;
                wz[i] <= in_z[i] + tz; // z sees only the model offset.
            end else if (phase == 2'd1) begin
                wx[i] <= wx[i] - cam_x;
                wy[i] <= wy[i] - cam_y;
            end else if (phase == 2'd2) begin
                wx[i] <= scale(wx[i], focal_length);
                wy[i] <= scale(wy[i], focal_length);
            end
        end
    end

    assign in.ready  = !in_full;
    assign out.valid = (phase == 2'd3);
    assign out.v0_x  = wx[0];
    assign out.v0_y  = wy[0];
    assign out.v0_z  = wz[0];
    assign out.v1_x  = wx[1];
    assign out.v1_y  = wy[1];
    assign out.v1_z  = wz[1];
    assign out.v2_x  = wx[2];
    assign out.v2_y  = wy[2];
    assign out.v2_z  = wz[2];
    assign out.color = w_color;
    assign busy      = in_full || (phase != 2'd0);

endmodule

// ==== design/rasterizer.sv ====
`timescale 1ns/1ps
`include "render_cfg.svh"

module rasterizer (
    input  logic clk,
    input  logic rst,
    tri_if.dst   in,
    pixel_if.src pix,
    output logic busy
);
    import render_pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP1, SETUP2, SCAN} state_t;
    typedef logic signed [15:0] pix_t;
    typedef logic signed [47:0] edge_t;

    localparam pix_t X_MAX = pix_t'(`RENDER_WIDTH - 1);
    localparam pix_t Y_MAX = pix_t'(`RENDER_HEIGHT - 1);

    state_t   state;
    pix_t     vx [3];
    pix_t     vy [3];
    q16_16_t  depth;
    color12_t color;
    edge_t    area;
    pix_t     box_x0;
    pix_t     box_x1;
    pix_t     box_y0;
    pix_t     box_y1;
    pix_t     px;
    pix_t     py;
    logic     flip;
    edge_t    e0;
    edge_t    e1;
    edge_t    e2;
    logic     covered;
    logic     advance;
    logic     reject;

    // positive when c lies left of a->b.
    function automatic edge_t edge_fn(input pix_t ax, input pix_t ay, input pix_t bx,
                                      input pix_t by, input pix_t cx, input pix_t cy);
        edge_t dx;
        edge_t dy;
        dx = edge_t'(bx) - edge_t'(ax);
        dy = edge_t'(by) - edge_t'(ay);
        return dx * (edge_t'(cy) - edge_t'(ay)) - dy * (edge_t'(cx) - edge_t'(ax));
    endfunction

    function automatic pix_t min3(input pix_t a, input pix_t b, input pix_t c);
        pix_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic pix_t max3(input pix_t a, input pix_t b, input pix_t c);
        pix_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    function automatic pix_t clamp(input pix_t v, input pix_t hi);
        if (v < 0) begin
            return '0;
        end
        return (v > hi) ? hi : v;
    endfunction

    always_comb begin
        e0 = edge_fn(vx[1], vy[1], vx[2], vy[2], px, py);
        e1 = edge_fn(vx[2], vy[2], vx[0], vy[0], px, py);
        e2 = edge_fn(vx[0], vy[0], vx[1], vy[1], px, py);
        if (flip) begin
            covered = (e0 <= 0) && (e1 <= 0) && (e2 <= 0);
        end else begin
            covered = (e0 >= 0) && (e1 >= 0) && (e2 >= 0);
        end
    end

    // degenerate, back facing or fully off screen.
    assign reject = (area == 0) || ((`RENDER_CULL != 0) && (area < 0)) ||
                    (box_x1 < 0) || (box_y1 < 0) || (box_x0 > X_MAX) || (box_y0 > Y_MAX);
    assign advance = !pix.valid || pix.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            area   <= '0;
            flip   <= 1'b0;
            box_x0 <= '0;
            box_x1 <= '0;
            box_y0 <= '0;
            box_y1 <= '0;
            px     <= '0;
            py     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (in.valid) begin
                        state <= SETUP1;
                    end
                end
                SETUP1: begin
                    area   <= edge_fn(vx[0], vy[0], vx[1], vy[1], vx[2], vy[2]);
                    box_x0 <= min3(vx[0], vx[1], vx[2]);
                    box_x1 <= max3(vx[0], vx[1], vx[2]);
                    box_y0 <= min3(vy[0], vy[1], vy[2]);
                    box_y1 <= max3(vy[0], vy[1], vy[2]);
                    state  <= SETUP2;
                end
                SETUP2: begin
                    if (reject) begin
                        state <= IDLE;
                    end else begin
                        flip   <= (area < 0);
                        box_x0 <= clamp(box_x0, X_MAX);
                        box_x1 <= clamp(box_x1, X_MAX);
                        box_y1 <= clamp(box_y1, Y_MAX);
                        px     <= clamp(box_x0, X_MAX);
                        py     <= clamp(box_y0, Y_MAX);
                        state  <= SCAN;
                    end
                end
                default: begin
                    if (advance) begin
                        if (px == box_x1) begin
                            px <= box_x0;
                            if (py == box_y1) begin
                                state <= IDLE;
                            end else begin
                                py <= py + 1'b1;
                            end
                        end else begin
                            px <= px + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // vertices truncated to whole pixels on accept.
    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            vx[0] <= in.v0_x[31:16];
            vy[0] <= in.v0_y[31:16];
            vx[1] <= in.v1_x[31:16];
            vy[1] <= in.v1_y[31:16];
            vx[2] <= in.v2_x[31:16];
            vy[2] <= in.v2_y[31:16];
            depth <= in.v0_z;
            color <= in.color;
        end
    end

    assign in.ready          = (state == IDLE);
    assign busy              = (state != IDLE);
    assign pix.valid         = (state == SCAN) && covered;
    assign pix.x             = coord_t'(px);
    assign pix.y             = coord_t'(py);
    assign pix.depth         = depth;
    assign pix.color         = color;
    assign pix.compare_depth = 1'b1;

endmodule

// ==== design/render_manager.sv ====
`timescale 1ns/1ps

module render_manager (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 begin_frame,
    input  render_pkg::color12_t fill_color,
    input  render_pkg::q16_16_t  focal_length,
    input  render_pkg::q16_16_t  cam_x,
    input  render_pkg::q16_16_t  cam_y,
    input  render_pkg::q16_16_t  tx,
    input  render_pkg::q16_16_t  ty,
    input  render_pkg::q16_16_t  tz,
    tri_if.dst                   tri_in,
    pixel_if.src                 pix_out,
    output logic                 busy
);
    import render_pkg::*;

    typedef enum logic [1:0] {FILL, FILL_WAIT, TRIANGLE} state_t;

    state_t   state;
    state_t   next_state;
    logic     raster_sel;
    logic     accept;
    logic     filler_busy;
    logic     xf_busy;
    logic     rast_busy;

    color12_t fill_q;
    q16_16_t  focal_q;
    q16_16_t  cam_x_q;
    q16_16_t  cam_y_q;
    q16_16_t  tx_q;
    q16_16_t  ty_q;
    q16_16_t  tz_q;

    tri_if   xf_in ();
    tri_if   xf_out ();
    pixel_if fill_pix ();
    pixel_if rast_pix ();

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FILL;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            FILL: next_state = FILL_WAIT;
            FILL_WAIT: begin
                if (!filler_busy) begin
                    next_state = TRIANGLE;
                end
            end
            TRIANGLE: begin
                if (begin_frame) begin
                    next_state = FILL;
                end
            end
            default: next_state = FILL;
        endcase
    end

    // frame values held for the whole frame, offsets held per triangle.
    always_ff @(posedge clk) begin
        if (state == FILL) begin
            fill_q  <= fill_color;
            focal_q <= focal_length;
            cam_x_q <= cam_x;
            cam_y_q <= cam_y;
        end
        if (accept) begin
            tx_q <= tx;
            ty_q <= ty;
            tz_q <= tz;
        end
    end

    assign raster_sel    = (state == TRIANGLE);
    assign accept        = tri_in.valid && tri_in.ready;
    assign tri_in.ready  = raster_sel && xf_in.ready;
    assign xf_in.valid   = raster_sel && tri_in.valid;
    assign xf_in.v0_x    = tri_in.v0_x;
    assign xf_in.v0_y    = tri_in.v0_y;
    assign xf_in.v0_z    = tri_in.v0_z;
    assign xf_in.v1_x    = tri_in.v1_x;
    assign xf_in.v1_y    = tri_in.v1_y;
    assign xf_in.v1_z    = tri_in.v1_z;
    assign xf_in.v2_x    = tri_in.v2_x;
    assign xf_in.v2_y    = tri_in.v2_y;
    assign xf_in.v2_z    = tri_in.v2_z;
    assign xf_in.color   = tri_in.color;

    screen_filler u_filler (
        .clk  (clk),
        .rst  (rst),
        .start(state == FILL),
        .color(fill_q),
        .busy (filler_busy),
        .pix  (fill_pix)
    );

    transformer u_xf (
        .clk         (clk),
        .rst         (rst),
        .focal_length(focal_q),
        .cam_x       (cam_x_q),
        .cam_y       (cam_y_q),
        .tx          (tx_q),
        .ty          (ty_q),
        .tz          (tz_q),
        .in          (xf_in),
        .out         (xf_out),
        .busy        (xf_busy)
    );

    rasterizer u_rast (
        .clk (clk),
        .rst (rst),
        .in  (xf_out),
        .pix (rast_pix),
        .busy(rast_busy)
    );

    // only the selected stream sees out_ready.
    assign fill_pix.ready        = !raster_sel && pix_out.ready;
    assign rast_pix.ready        = raster_sel && pix_out.ready;
    assign pix_out.x             = raster_sel ? rast_pix.x : fill_pix.x;
    assign pix_out.y             = raster_sel ? rast_pix.y : fill_pix.y;
    assign pix_out.depth         = raster_sel ? rast_pix.depth : fill_pix.depth;
    assign pix_out.color         = raster_sel ? rast_pix.color : fill_pix.color;
    assign pix_out.compare_depth = raster_sel ? rast_pix.compare_depth : fill_pix.compare_depth;
    assign pix_out.valid         = raster_sel ? rast_pix.valid : fill_pix.valid;

    assign busy = (state == FILL) || filler_busy || xf_busy || rast_busy;

endmodule

// ==== design/render_top.sv ====
`timescale 1ns/1ps

module render_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 begin_frame,
    input  logic                 reg_wr,
    input  logic [1:0]           reg_addr,
    input  render_pkg::q16_16_t  reg_data,
    input  render_pkg::q16_16_t  tri_v0x,
    input  render_pkg::q16_16_t  tri_v0y,
    input  render_pkg::q16_16_t  tri_v0z,
    input  render_pkg::q16_16_t  tri_v1x,
    input  render_pkg::q16_16_t  tri_v1y,
    input  render_pkg::q16_16_t  tri_v1z,
    input  render_pkg::q16_16_t  tri_v2x,
    input  render_pkg::q16_16_t  tri_v2y,
    input  render_pkg::q16_16_t  tri_v2z,
    input  render_pkg::color12_t tri_color,
    input  render_pkg::q16_16_t  tri_tx,
    input  render_pkg::q16_16_t  tri_ty,
    input  render_pkg::q16_16_t  tri_tz,
    input  logic                 tri_valid,
    output logic                 tri_ready,
    output render_pkg::coord_t   out_x,
    output render_pkg::coord_t   out_y,
    output render_pkg::q16_16_t  out_depth,
    output render_pkg::color12_t out_color,
    output logic                 out_compare_depth,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 busy
);
    import render_pkg::*;

    color12_t fill_color;
    q16_16_t  focal_length;
    q16_16_t  cam_x;
    q16_16_t  cam_y;

    tri_if   tri_bus ();
    pixel_if pix_bus ();

    assign tri_bus.v0_x  = tri_v0x;
    assign tri_bus.v0_y  = tri_v0y;
    assign tri_bus.v0_z  = tri_v0z;
    assign tri_bus.v1_x  = tri_v1x;
    assign tri_bus.v1_y  = tri_v1y;
    assign tri_bus.v1_z  = tri_v1z;
    assign tri_bus.v2_x  = tri_v2x;
    assign tri_bus.v2_y  = tri_v2y;
    assign tri_bus.v2_z  = tri_v2z;
    assign tri_bus.color = tri_color;
    assign tri_bus.valid = tri_valid;
    assign tri_ready     = tri_bus.ready;

    assign out_x             = pix_bus.x;
    assign out_y             = pix_bus.y;
    assign out_depth         = pix_bus.depth;
    assign out_color         = pix_bus.color;
    assign out_compare_depth = pix_bus.compare_depth;
    assign out_valid         = pix_bus.valid;
    assign pix_bus.ready     = out_ready;

    render_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .fill_color  (fill_color),
        .focal_length(focal_length),
        .cam_x       (cam_x),
        .cam_y       (cam_y)
    );

    render_manager u_mgr (
        .clk         (clk),
        .rst         (rst),
        .begin_frame (begin_frame),
        .fill_color  (fill_color),
        .focal_length(focal_length),
        .cam_x       (cam_x),
        .cam_y       (cam_y),
        .tx          (tri_tx),
        .ty          (tri_ty),
        .tz          (tri_tz),
        .tri_in      (tri_bus),
        .pix_out     (pix_bus),
        .busy        (busy)
    );

endmodule

// ==== dv/render_tb.sv ====
`timescale 1ns/1ps
`include "render_cfg.svh"

module render_tb;

    localparam int WAIT_LIMIT = 5000; // cycles per wait loop.
    localparam int SCREEN     = `RENDER_WIDTH * `RENDER_HEIGHT;

    logic        clk;
    logic        rst;
    logic        begin_frame;
    logic        reg_wr;
    logic [1:0]  reg_addr;
    logic [31:0] reg_data;
    logic [31:0] tri_in [13]; // v0 xyz, v1 xyz, v2 xyz, colour, tx, ty, tz.
    logic [31:0] tri_vals [13];
    logic        tri_valid;
    logic        tri_ready;
    logic [15:0] out_x;
    logic [15:0] out_y;
    logic [31:0] out_depth;
    logic [11:0] out_color;
    logic        out_compare_depth;
    logic        out_valid;
    logic        out_ready;
    logic        busy;
    logic        stall_en;
    logic [31:0] lcg_state;
    logic [76:0] pix_log [$]; // {x, y, depth, colour, compare_depth}.
    logic [SCREEN-1:0] seen;
    int          expects_run;

    render_top UUT (
        .clk              (clk),
        .rst              (rst),
        .begin_frame      (begin_frame),
        .reg_wr           (reg_wr),
        .reg_addr         (reg_addr),
        .reg_data         (reg_data),
        .tri_v0x          (tri_in[0]),
        .tri_v0y          (tri_in[1]),
        .tri_v0z          (tri_in[2]),
        .tri_v1x          (tri_in[3]),
        .tri_v1y          (tri_in[4]),
        .tri_v1z          (tri_in[5]),
        .tri_v2x          (tri_in[6]),
        .tri_v2y          (tri_in[7]),
        .tri_v2z          (tri_in[8]),
        .tri_color        (tri_in[9][11:0]),
        .tri_tx           (tri_in[10]),
        .tri_ty           (tri_in[11]),
        .tri_tz           (tri_in[12]),
        .tri_valid        (tri_valid),
        .tri_ready        (tri_ready),
        .out_x            (out_x),
        .out_y            (out_y),
        .out_depth        (out_depth),
        .out_color        (out_color),
        .out_compare_depth(out_compare_depth),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .busy             (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // out_ready low on about one cycle in four while stalls are on.
    initial begin
        out_ready = 1'b1;
        lcg_state = 32'd79236;
        forever begin
            @(posedge clk);
            #2;
            if (stall_en) begin
                lcg_state = lcg_next(lcg_state);
                out_ready = (lcg_state[17:16] != 2'b00);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // logs each pixel that transfers on the next rising edge.
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            pix_log.push_back({out_x, out_y, out_depth, out_color, out_compare_depth});
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_fields(input int got, input int want, input string line);
        if (got != want) begin
            stop_run($sformatf("malformed line in the vector file: %s", line));
        end
    endtask

    task automatic wait_tri_ready(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!tri_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run($sformatf("timeout waiting for tri_ready %s", what));
            end
            @(negedge clk);
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        reg_wr   = 1'b1;
        reg_addr = addr;
        reg_data = data;
        @(posedge clk);
        #2;
        reg_wr = 1'b0;
    endtask

    task automatic start_frame();
        wait_tri_ready("before begin_frame");
        @(posedge clk);
        #2;
        begin_frame = 1'b1;
        @(posedge clk);
        #2;
        begin_frame = 1'b0;
    endtask

    task automatic send_triangle();
        @(posedge clk);
        #2;
        foreach (tri_in[i]) begin
            tri_in[i] = tri_vals[i];
        end
        tri_valid = 1'b1;
        wait_tri_ready("to accept a triangle");
        @(posedge clk);
        #2;
        tri_valid = 1'b0;
    endtask

    // waits for the stream to finish, then checks every logged pixel.
    task automatic check_stream(input logic [31:0] exp_count, input logic [31:0] exp_sum,
                                input logic [11:0] exp_color, input logic [31:0] exp_depth,
                                input logic exp_cmp);
        int          waited;
        int          idx;
        logic [31:0] sum;
        logic [76:0] p;
        waited = 0;
        @(negedge clk);
        while (busy) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("timeout waiting for busy to fall at the end of a stream");
            end
            @(negedge clk);
        end
        compare("pixel_count", pix_log.size(), exp_count);
        sum  = '0;
        seen = '0;
        foreach (pix_log[i]) begin
            p = pix_log[i];
            if (p[76:61] >= `RENDER_WIDTH || p[60:45] >= `RENDER_HEIGHT) begin
                stop_run("a pixel lies outside the screen");
            end
            idx = int'(p[60:45]) * `RENDER_WIDTH + int'(p[76:61]);
            if (seen[idx]) begin
                stop_run("a pixel location was sent twice in one stream");
            end
            seen[idx] = 1'b1;
            sum = sum + p[76:61] + 32 * p[60:45];
            compare("out_depth", p[44:13], exp_depth);
            compare("out_color", p[12:1], exp_color);
            compare("out_compare_depth", p[0], exp_cmp);
        end
        compare("pixel_checksum", sum, exp_sum);
        if (exp_cmp) begin
            compare("tri_ready", tri_ready, 1'b1); // triangle path idle again.
        end
        pix_log.delete();
        expects_run++;
    endtask

    initial begin
        string       line;
        byte         cmd;
        int          fd;
        int          n;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] e_count;
        logic [31:0] e_sum;
        logic [31:0] e_color;
        logic [31:0] e_depth;
        logic [31:0] e_cmp;
        rst         = 1'b1;
        begin_frame = 1'b0;
        reg_wr      = 1'b0;
        reg_addr    = '0;
        reg_data    = '0;
        tri_valid   = 1'b0;
        stall_en    = 1'b0;
        expects_run = 0;
        foreach (tri_in[i]) begin
            tri_in[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        // still in FILL, the filler starts on the next edge.
        @(negedge clk);
        compare("busy", busy, 1'b1);
        compare("out_valid", out_valid, 1'b0);
        compare("tri_ready", tri_ready, 1'b0);
        fd = $fopen("dv/render_vectors.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open dv/render_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            cmd = line.getc(0);
            case (cmd)
                "W": begin
                    n = $sscanf(line, "W %h %h", a0, a1);
                    check_fields(n, 2, line);
                    write_reg(a0[1:0], a1);
                end
                "B": start_frame();
                "S": begin
                    n = $sscanf(line, "S %d", a0);
                    check_fields(n, 1, line);
                    stall_en = a0[0];
                end
                "T": begin
                    n = $sscanf(line, "T %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                tri_vals[0], tri_vals[1], tri_vals[2], tri_vals[3],
                                tri_vals[4], tri_vals[5], tri_vals[6], tri_vals[7],
                                tri_vals[8], tri_vals[9], tri_vals[10], tri_vals[11],
                                tri_vals[12]);
                    check_fields(n, 13, line);
                    send_triangle();
                end
                "E": begin
                    n = $sscanf(line, "E %d %d %h %h %d", e_count, e_sum, e_color,
                                e_depth, e_cmp);
                    check_fields(n, 5, line);
                    check_stream(e_count, e_sum, e_color[11:0], e_depth, e_cmp[0]);
                end
                default: ; // comments and blank lines.
            endcase
        end
        $fclose(fd);
        if (expects_run > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_run("the vector file held no expected results");
        end
    end

endmodule

// ==== dv/render_vectors.txt ====
# W addr data(hex) | B | S stall(0/1) | T v0x v0y v0z v1x v1y v1z v2x v2y v2z color tx ty tz (hex)
# E count checksum (decimal) color depth (hex) compare_depth
E 768 294528 000 7fffffff 0
W 0 000000f0
B
E 768 294528 0f0 7fffffff 0
T 00000000 00000000 00020000 00040000 00000000 00020000 00000000 00040000 00020000 f00 00000000 00000000 00000000
E 15 660 f00 00020000 1
T 00000000 00000000 00020000 00000000 00040000 00020000 00040000 00000000 00020000 0ff 00000000 00000000 00000000
E 0 0 0ff 00020000 1
T 00000000 00000000 00020000 00040000 00000000 00020000 00000000 00040000 00020000 0a5 000a0000 00050000 00010000
E 15 3210 0a5 00030000 1
# camera and fill colour written mid-frame, applied at the next begin frame
W 2 00030000
W 3 00020000
W 0 0000000f
T 00000000 00000000 00020000 00040000 00000000 00020000 00000000 00040000 00020000 f00 00000000 00000000 00000000
E 15 660 f00 00020000 1
B
E 768 294528 00f 7fffffff 0
T 00000000 00000000 00020000 00040000 00000000 00020000 00000000 00040000 00020000 0a5 000a0000 00050000 00010000
E 15 2205 0a5 00030000 1
W 1 00020000
W 2 00000000
W 3 00000000
B
E 768 294528 00f 7fffffff 0
T 00000000 00000000 00020000 00040000 00000000 00020000 00000000 00040000 00020000 f00 00000000 00000000 00000000
E 45 3960 f00 00020000 1
# same streams again with random out_ready stalls
S 1
B
E 768 294528 00f 7fffffff 0
T 00000000 00000000 00020000 00040000 00000000 00020000 00000000 00040000 00020000 f00 00000000 00000000 00000000
E 45 3960 f00 00020000 1
T 00000000 00000000 00020000 00040000 00000000 00020000 00000000 00040000 00020000 0a5 000a0000 00050000 00010000
E 45 19260 0a5 00030000 1
T 00000000 00000000 00020000 00000000 00040000 00020000 00040000 00000000 00020000 0ff 00000000 00000000 00000000
E 0 0 0ff 00020000 1

// ==== src.f ====
+incdir+design
design/render_pkg.sv
design/tri_if.sv
design/pixel_if.sv
design/render_regs.sv
design/screen_filler.sv
design/transformer.sv
design/rasterizer.sv
design/render_manager.sv
design/render_top.sv
dv/render_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module render_tb -f src.f -o render_sim \
    && ./obj_dir/render_sim | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null \
    && echo "render simulation: pass" \
    || { echo "render simulation: fail"; exit 1; }
